//--- include/bus_macros.svh
`ifndef BUS_MACROS_SVH
`define BUS_MACROS_SVH

// ============================================================
// bus geometry
// ============================================================
`define BUS_ADDR_W 32
`define BUS_DATA_W 32
`define BUS_STRB_W 4
// low address bits decoded by the slaves
`define BUS_OFS_W 12

// memory depth as word-index bits, 1024 words
`define SRAM_AW 10

// ============================================================
// serial device address map
// ============================================================
`define UART_REGION 20'ha0000
`define UART_TX_OFS 12'h3f8

`endif

//--- design/bus_pkg.sv
`include "bus_macros.svh"

package bus_pkg;

	// ============================================================
	// response codes
	// ============================================================
	typedef enum logic [1:0] {
		OKAY   = 2'b00,
		SLVERR = 2'b10
	} resp_e;

	// ============================================================
	// address word, raw or split into region and offset
	// ============================================================
	typedef struct packed {
		logic [`BUS_ADDR_W-`BUS_OFS_W-1:0] region;
		logic [`BUS_OFS_W-1:0]             offset;
	} addr_fields_t;

	// arbiter reads the region, slaves read the offset
	typedef union packed {
		logic [`BUS_ADDR_W-1:0] raw;
		addr_fields_t           f;
	} addr_u;

	// ============================================================
	// channel payloads
	// ============================================================
	typedef struct packed {
		addr_u addr;
		logic  valid;
	} ar_req_t;

	typedef struct packed {
		addr_u addr;
		logic  valid;
	} aw_req_t;

	typedef struct packed {
		logic [`BUS_DATA_W-1:0] data;
		logic [`BUS_STRB_W-1:0] strb;
		logic                   valid;
	} w_req_t;

	typedef struct packed {
		logic [`BUS_DATA_W-1:0] data;
		resp_e                  resp;
		logic                   valid;
	} r_rsp_t;

	typedef struct packed {
		resp_e resp;
		logic  valid;
	} b_rsp_t;

endpackage

//--- design/bus_arbiter.sv
`timescale 1ns/1ps
`include "bus_macros.svh"

module bus_arbiter (
	input  logic             clk,
	input  logic             rst,

	// fetch master, read only
	input  bus_pkg::ar_req_t if_ar_i,
	output logic             if_arready_o,
	output bus_pkg::r_rsp_t  if_r_o,
	input  logic             if_rready_i,

	// data master
	input  bus_pkg::ar_req_t d_ar_i,
	output logic             d_arready_o,
	output bus_pkg::r_rsp_t  d_r_o,
	input  logic             d_rready_i,
	input  bus_pkg::aw_req_t d_aw_i,
	output logic             d_awready_o,
	input  bus_pkg::w_req_t  d_w_i,
	output logic             d_wready_o,
	output bus_pkg::b_rsp_t  d_b_o,
	input  logic             d_bready_i,

	// memory slave
	output bus_pkg::ar_req_t mem_ar_o,
	input  logic             mem_arready_i,
	input  bus_pkg::r_rsp_t  mem_r_i,
	output logic             mem_rready_o,
	output bus_pkg::aw_req_t mem_aw_o,
	input  logic             mem_awready_i,
	output bus_pkg::w_req_t  mem_w_o,
	input  logic             mem_wready_i,
	input  bus_pkg::b_rsp_t  mem_b_i,
	output logic             mem_bready_o,

	// serial slave, write only
	output bus_pkg::aw_req_t uart_aw_o,
	input  logic             uart_awready_i,
	output bus_pkg::w_req_t  uart_w_o,
	input  logic             uart_wready_i,
	input  bus_pkg::b_rsp_t  uart_b_i,
	output logic             uart_bready_o
);

	typedef enum logic [2:0] {
		G_IDLE,
		G_FETCH,
		G_DREAD,
		G_UWRITE,
		G_MWRITE
	} grant_e;

	grant_e grant_q;
	grant_e grant_d;
	logic   aw_is_uart;

	assign aw_is_uart = (d_aw_i.addr.f.region == `UART_REGION);

	// ============================================================
	// grant state
	// ============================================================
	always_ff @(posedge clk) begin
		if (rst) begin
			grant_q <= G_IDLE;
		end else begin
			grant_q <= grant_d;
		end
	end

	// fixed priority: fetch, data read, serial write, memory write
	always_comb begin
		grant_d = grant_q;
		case (grant_q)
			G_IDLE: begin
				if (if_ar_i.valid)
					grant_d = G_FETCH;
				else if (d_ar_i.valid)
					grant_d = G_DREAD;
				else if (d_aw_i.valid && aw_is_uart)
					grant_d = G_UWRITE;
				else if (d_aw_i.valid)
					grant_d = G_MWRITE;
			end
			// release once the response handshake completes
			G_FETCH: if (mem_r_i.valid && if_rready_i) grant_d = G_IDLE;
			G_DREAD: if (mem_r_i.valid && d_rready_i) grant_d = G_IDLE;
			G_UWRITE: if (uart_b_i.valid && d_bready_i) grant_d = G_IDLE;
			G_MWRITE: if (mem_b_i.valid && d_bready_i) grant_d = G_IDLE;
			default: grant_d = G_IDLE;
		endcase
	end

	// ============================================================
	// channel routing
	// ============================================================
	always_comb begin
		// nothing passes unless granted
		if_arready_o  = 1'b0;
		if_r_o        = '0;
		d_arready_o   = 1'b0;
		d_r_o         = '0;
		d_awready_o   = 1'b0;
		d_wready_o    = 1'b0;
		d_b_o         = '0;
		mem_ar_o      = '0;
		mem_rready_o  = 1'b0;
		mem_aw_o      = '0;
		mem_w_o       = '0;
		mem_bready_o  = 1'b0;
		uart_aw_o     = '0;
		uart_w_o      = '0;
		uart_bready_o = 1'b0;

		case (grant_q)
			G_FETCH: begin
				mem_ar_o     = if_ar_i;
				if_arready_o = mem_arready_i;
				if_r_o       = mem_r_i;
				mem_rready_o = if_rready_i;
			end
			G_DREAD: begin
				mem_ar_o     = d_ar_i;
				d_arready_o  = mem_arready_i;
				d_r_o        = mem_r_i;
				mem_rready_o = d_rready_i;
			end
			G_UWRITE: begin
				uart_aw_o     = d_aw_i;
				uart_w_o      = d_w_i;
				d_awready_o   = uart_awready_i;
				d_wready_o    = uart_wready_i;
				d_b_o         = uart_b_i;
				uart_bready_o = d_bready_i;
			end
			G_MWRITE: begin
				mem_aw_o     = d_aw_i;
				mem_w_o      = d_w_i;
				d_awready_o  = mem_awready_i;
				d_wready_o   = mem_wready_i;
				d_b_o        = mem_b_i;
				mem_bready_o = d_bready_i;
			end
			default: ;
		endcase
	end

	// ============================================================
	// checks
	// ============================================================
	// a write goes to exactly one slave
	assert property (@(posedge clk) disable iff (rst)
		!(mem_b_i.valid && uart_b_i.valid))
		else $error("write answered by memory and serial device at once");

	// read grant holds while its data waits for the master
	assert property (@(posedge clk) disable iff (rst)
		(if_r_o.valid && !if_rready_i) |=> (if_r_o.valid && $stable(if_r_o.data)))
		else $error("fetch read grant dropped with data pending");

	assert property (@(posedge clk) disable iff (rst)
		(d_r_o.valid && !d_rready_i) |=> (d_r_o.valid && $stable(d_r_o.data)))
		else $error("data read grant dropped with data pending");

endmodule

//--- design/sram_slave.sv
`timescale 1ns/1ps
`include "bus_macros.svh"

module sram_slave (
	input  logic             clk,
	input  logic             rst,
	input  bus_pkg::ar_req_t ar_i,
	output logic             arready_o,
	output bus_pkg::r_rsp_t  r_o,
	input  logic             rready_i,
	input  bus_pkg::aw_req_t aw_i,
	output logic             awready_o,
	input  bus_pkg::w_req_t  w_i,
	output logic             wready_o,
	output bus_pkg::b_rsp_t  b_o,
	input  logic             bready_i
);

	import bus_pkg::*;

	typedef enum logic [1:0] {
		S_IDLE,
		S_RRSP,
		S_BRSP
	} sram_state_e;

	sram_state_e state_q;

	logic [`BUS_DATA_W-1:0] mem [0:(1 << `SRAM_AW)-1];
	logic [`BUS_DATA_W-1:0] rdata_q;
	logic [`SRAM_AW-1:0]    rd_idx;
	logic [`SRAM_AW-1:0]    wr_idx;
	logic                   rd_acc;
	logic                   wr_acc;

	// word index from offset bits 11:2
	assign rd_idx = ar_i.addr.f.offset[`SRAM_AW+1:2];
	assign wr_idx = aw_i.addr.f.offset[`SRAM_AW+1:2];

	assign arready_o = (state_q == S_IDLE);
	assign rd_acc    = arready_o && ar_i.valid;
	// write needs address and data together, read wins a tie
	assign wr_acc    = (state_q == S_IDLE) && aw_i.valid && w_i.valid && !ar_i.valid;
	assign awready_o = wr_acc;
	assign wready_o  = wr_acc;

	// ============================================================
	// transaction state
	// ============================================================
	always_ff @(posedge clk) begin
		if (rst) begin
			state_q <= S_IDLE;
		end else begin
			case (state_q)
				S_IDLE: begin
					if (rd_acc)
						state_q <= S_RRSP;
					else if (wr_acc)
						state_q <= S_BRSP;
				end
				S_RRSP: if (rready_i) state_q <= S_IDLE;
				S_BRSP: if (bready_i) state_q <= S_IDLE;
				default: state_q <= S_IDLE;
			endcase
		end
	end

	// ============================================================
	// storage
	// ============================================================
	always_ff @(posedge clk) begin
		if (rd_acc)
			rdata_q <= mem[rd_idx];
		if (wr_acc) begin
			for (int i = 0; i < `BUS_STRB_W; i++) begin
				if (w_i.strb[i])
					mem[wr_idx][8*i +: 8] <= w_i.data[8*i +: 8];
			end
		end
	end

	assign r_o.data  = rdata_q;
	assign r_o.resp  = OKAY;
	assign r_o.valid = (state_q == S_RRSP);

	assign b_o.resp  = OKAY;
	assign b_o.valid = (state_q == S_BRSP);

	// read data steady until taken
	assert property (@(posedge clk) disable iff (rst)
		(r_o.valid && !rready_i) |=> (r_o.valid && $stable(r_o.data)))
		else $error("read response changed before acceptance");

endmodule

//--- design/uart_slave.sv
`timescale 1ns/1ps
`include "bus_macros.svh"

module uart_slave (
	input  logic             clk,
	input  logic             rst,
	input  bus_pkg::aw_req_t aw_i,
	output logic             awready_o,
	input  bus_pkg::w_req_t  w_i,
	output logic             wready_o,
	output bus_pkg::b_rsp_t  b_o,
	input  logic             bready_i,
	output logic [7:0]       tx_byte_o,
	output logic             tx_valid_o
);

	import bus_pkg::*;

	logic       b_valid_q;
	resp_e      b_resp_q;
	logic       tx_valid_q;
	logic [7:0] tx_byte_q;
	logic       wr_acc;
	logic       ofs_hit;

	// one write at a time, no new accept while a response is pending
	assign wr_acc    = !b_valid_q && aw_i.valid && w_i.valid;
	assign awready_o = wr_acc;
	assign wready_o  = wr_acc;

	assign ofs_hit = (aw_i.addr.f.offset == `UART_TX_OFS);

	// ============================================================
	// response and transmit strobe
	// ============================================================
	always_ff @(posedge clk) begin
		if (rst) begin
			b_valid_q  <= 1'b0;
			b_resp_q   <= OKAY;
			tx_valid_q <= 1'b0;
		end else begin
			// strobe lasts one cycle only
			tx_valid_q <= wr_acc && ofs_hit && w_i.strb[0];
			if (wr_acc) begin
				b_valid_q <= 1'b1;
				b_resp_q  <= ofs_hit ? OKAY : SLVERR;
			end else if (bready_i) begin
				b_valid_q <= 1'b0;
			end
		end
	end

	// byte register, payload only
	always_ff @(posedge clk) begin
		if (wr_acc && ofs_hit && w_i.strb[0])
			tx_byte_q <= w_i.data[7:0];
	end

	assign b_o.valid  = b_valid_q;
	assign b_o.resp   = b_resp_q;
	assign tx_byte_o  = tx_byte_q;
	assign tx_valid_o = tx_valid_q;

	// one pulse per accepted write
	assert property (@(posedge clk) disable iff (rst)
		tx_valid_o |=> !tx_valid_o)
		else $error("tx strobe high for two cycles");

endmodule

//--- design/mem_subsys_top.sv
`timescale 1ns/1ps

module mem_subsys_top (
	input  logic             clk,
	input  logic             rst,

	// fetch port
	input  bus_pkg::ar_req_t if_ar_i,
	output logic             if_arready_o,
	output bus_pkg::r_rsp_t  if_r_o,
	input  logic             if_rready_i,

	// data port
	input  bus_pkg::ar_req_t d_ar_i,
	output logic             d_arready_o,
	output bus_pkg::r_rsp_t  d_r_o,
	input  logic             d_rready_i,
	input  bus_pkg::aw_req_t d_aw_i,
	output logic             d_awready_o,
	input  bus_pkg::w_req_t  d_w_i,
	output logic             d_wready_o,
	output bus_pkg::b_rsp_t  d_b_o,
	input  logic             d_bready_i,

	// serial transmit side
	output logic [7:0]       tx_byte_o,
	output logic             tx_valid_o
);

	import bus_pkg::*;

	// ============================================================
	// arbiter to slaves
	// ============================================================
	ar_req_t mem_ar;
	r_rsp_t  mem_r;
	aw_req_t mem_aw;
	w_req_t  mem_w;
	b_rsp_t  mem_b;
	logic    mem_arready;
	logic    mem_rready;
	logic    mem_awready;
	logic    mem_wready;
	logic    mem_bready;

	aw_req_t uart_aw;
	w_req_t  uart_w;
	b_rsp_t  uart_b;
	logic    uart_awready;
	logic    uart_wready;
	logic    uart_bready;

	bus_arbiter bus_arbiter_i (
		.clk            (clk),
		.rst            (rst),
		.if_ar_i        (if_ar_i),
		.if_arready_o   (if_arready_o),
		.if_r_o         (if_r_o),
		.if_rready_i    (if_rready_i),
		.d_ar_i         (d_ar_i),
		.d_arready_o    (d_arready_o),
		.d_r_o          (d_r_o),
		.d_rready_i     (d_rready_i),
		.d_aw_i         (d_aw_i),
		.d_awready_o    (d_awready_o),
		.d_w_i          (d_w_i),
		.d_wready_o     (d_wready_o),
		.d_b_o          (d_b_o),
		.d_bready_i     (d_bready_i),
		.mem_ar_o       (mem_ar),
		.mem_arready_i  (mem_arready),
		.mem_r_i        (mem_r),
		.mem_rready_o   (mem_rready),
		.mem_aw_o       (mem_aw),
		.mem_awready_i  (mem_awready),
		.mem_w_o        (mem_w),
		.mem_wready_i   (mem_wready),
		.mem_b_i        (mem_b),
		.mem_bready_o   (mem_bready),
		.uart_aw_o      (uart_aw),
		.uart_awready_i (uart_awready),
		.uart_w_o       (uart_w),
		.uart_wready_i  (uart_wready),
		.uart_b_i       (uart_b),
		.uart_bready_o  (uart_bready)
	);

	sram_slave sram_slave_i (
		.clk       (clk),
		.rst       (rst),
		.ar_i      (mem_ar),
		.arready_o (mem_arready),
		.r_o       (mem_r),
		.rready_i  (mem_rready),
		.aw_i      (mem_aw),
		.awready_o (mem_awready),
		.w_i       (mem_w),
		.wready_o  (mem_wready),
		.b_o       (mem_b),
		.bready_i  (mem_bready)
	);

	uart_slave uart_slave_i (
		.clk        (clk),
		.rst        (rst),
		.aw_i       (uart_aw),
		.awready_o  (uart_awready),
		.w_i        (uart_w),
		.wready_o   (uart_wready),
		.b_o        (uart_b),
		.bready_i   (uart_bready),
		.tx_byte_o  (tx_byte_o),
		.tx_valid_o (tx_valid_o)
	);

endmodule

//--- verification/tb_mem_subsys.sv
`timescale 1ns/1ps
`include "bus_macros.svh"

module tb_mem_subsys;

	import bus_pkg::*;

	localparam int clk_period   = 10;
	localparam int reset_cycles = 16;
	localparam int num_words    = 6;
	// transactions: test 2 four per word, tests 3 to 6 thirteen more
	localparam int txn_count    = num_words * 4 + 13;
	localparam int txn_cycles   = 8;
	localparam int hold_cycles  = 5;
	localparam int run_cycles   = reset_cycles + 4 + txn_count * txn_cycles + hold_cycles;
	localparam int watchdog_ns  = run_cycles * clk_period * 4;
	localparam logic [11:0] tx_ofs = `UART_TX_OFS;

	logic    clk;
	logic    rst;
	ar_req_t if_ar;
	logic    if_arready;
	r_rsp_t  if_r;
	logic    if_rready;
	ar_req_t d_ar;
	logic    d_arready;
	r_rsp_t  d_r;
	logic    d_rready;
	aw_req_t d_aw;
	logic    d_awready;
	w_req_t  d_w;
	logic    d_wready;
	b_rsp_t  d_b;
	logic    d_bready;
	logic [7:0] tx_byte;
	logic       tx_valid;

	// reference model, filled only through full-strobe writes first
	logic [31:0] ref_mem [0:(1 << `SRAM_AW)-1];
	integer      seed = 32'hb9b2;
	int          errors = 0;
	int          checks = 0;
	int          tx_count = 0;
	logic [7:0]  tx_last;
	time         fetch_done_t;
	time         write_done_t;

	mem_subsys_top mem_subsys_top_i (
		.clk          (clk),
		.rst          (rst),
		.if_ar_i      (if_ar),
		.if_arready_o (if_arready),
		.if_r_o       (if_r),
		.if_rready_i  (if_rready),
		.d_ar_i       (d_ar),
		.d_arready_o  (d_arready),
		.d_r_o        (d_r),
		.d_rready_i   (d_rready),
		.d_aw_i       (d_aw),
		.d_awready_o  (d_awready),
		.d_w_i        (d_w),
		.d_wready_o   (d_wready),
		.d_b_o        (d_b),
		.d_bready_i   (d_bready),
		.tx_byte_o    (tx_byte),
		.tx_valid_o   (tx_valid)
	);

	initial begin
		clk = 1'b0;
		forever #(clk_period / 2) clk = ~clk;
	end

	// transmit strobe monitor, sampled mid-cycle
	always @(negedge clk) begin
		if (tx_valid === 1'b1) begin
			tx_count++;
			tx_last = tx_byte;
		end
	end

	initial begin
		#(watchdog_ns);
		$display("watchdog expired after %0d ns, a transaction never completed", watchdog_ns);
		$display("SIMULATION FAILED");
		$finish;
	end

	// ============================================================
	// helpers
	// ============================================================
	task automatic check_value(input string name, input logic [31:0] got,
			input logic [31:0] exp);
		checks++;
		assert (got === exp)
		else begin
			errors++;
			$display("[ERROR] %0t %s: expected %h, got %h", $time, name, exp, got);
		end
	endtask

	function automatic logic [31:0] merge_strobe(input logic [31:0] old,
			input logic [31:0] data, input logic [3:0] strb);
		logic [31:0] res;
		res = old;
		for (int i = 0; i < 4; i++) begin
			if (strb[i])
				res[8*i +: 8] = data[8*i +: 8];
		end
		return res;
	endfunction

	function automatic logic [31:0] word_addr(input logic [19:0] region, input logic [9:0] idx);
		return {region, idx, 2'b00};
	endfunction

	task automatic fetch_read(input logic [31:0] addr, output logic [31:0] data,
			output logic [1:0] resp);
		@(posedge clk);
		#1;
		if_ar.addr.raw = addr;
		if_ar.valid    = 1'b1;
		if_rready      = 1'b1;
		do @(negedge clk); while (if_arready !== 1'b1);
		@(posedge clk);
		#1;
		if_ar.valid = 1'b0;
		do @(negedge clk); while (if_r.valid !== 1'b1);
		data         = if_r.data;
		resp         = if_r.resp;
		fetch_done_t = $time;
		@(posedge clk);
		#1;
		if_rready = 1'b0;
	endtask

	task automatic data_read(input logic [31:0] addr, output logic [31:0] data,
			output logic [1:0] resp);
		@(posedge clk);
		#1;
		d_ar.addr.raw = addr;
		d_ar.valid    = 1'b1;
		d_rready      = 1'b1;
		do @(negedge clk); while (d_arready !== 1'b1);
		@(posedge clk);
		#1;
		d_ar.valid = 1'b0;
		do @(negedge clk); while (d_r.valid !== 1'b1);
		data = d_r.data;
		resp = d_r.resp;
		@(posedge clk);
		#1;
		d_rready = 1'b0;
	endtask

	task automatic data_write(input logic [31:0] addr, input logic [31:0] data,
			input logic [3:0] strb, output logic [1:0] resp);
		@(posedge clk);
		#1;
		d_aw.addr.raw = addr;
		d_aw.valid    = 1'b1;
		d_w.data      = data;
		d_w.strb      = strb;
		d_w.valid     = 1'b1;
		d_bready      = 1'b1;
		// address and data are accepted together
		do @(negedge clk); while (d_awready !== 1'b1);
		check_value("d_wready_o", d_wready, 1'b1);
		@(posedge clk);
		#1;
		d_aw.valid = 1'b0;
		d_w.valid  = 1'b0;
		do @(negedge clk); while (d_b.valid !== 1'b1);
		resp         = d_b.resp;
		write_done_t = $time;
		@(posedge clk);
		#1;
		d_bready = 1'b0;
	endtask

	task automatic check_idle_outputs();
		check_value("if_arready_o", if_arready, 1'b0);
		check_value("d_arready_o", d_arready, 1'b0);
		check_value("d_awready_o", d_awready, 1'b0);
		check_value("d_wready_o", d_wready, 1'b0);
		check_value("if_r_o.valid", if_r.valid, 1'b0);
		check_value("d_r_o.valid", d_r.valid, 1'b0);
		check_value("d_b_o.valid", d_b.valid, 1'b0);
		check_value("tx_valid_o", tx_valid, 1'b0);
	endtask

	// ============================================================
	// directed tests
	// ============================================================
	task automatic test_reset();
		rst    = 1'b1;
		if_ar  = '0;
		d_ar   = '0;
		d_aw   = '0;
		d_w    = '0;
		if_rready = 1'b0;
		d_rready  = 1'b0;
		d_bready  = 1'b0;
		repeat (reset_cycles - 1) begin
			@(negedge clk);
			check_idle_outputs();
		end
		@(posedge clk);
		#1;
		rst = 1'b0;
		repeat (3) begin
			@(negedge clk);
			check_idle_outputs();
		end
	endtask

	task automatic test_strobe_rw();
		logic [9:0]  idx [num_words];
		logic [31:0] data;
		logic [31:0] rd;
		logic [3:0]  strb;
		logic [1:0]  resp;
		for (int i = 0; i < num_words; i++) begin
			idx[i] = $random(seed);
			data   = $random(seed);
			data_write(word_addr(20'h0, idx[i]), data, 4'hf, resp);
			check_value("d_b_o.resp", resp, OKAY);
			ref_mem[idx[i]] = data;
		end
		for (int i = 0; i < num_words; i++) begin
			data = $random(seed);
			strb = $random(seed);
			data_write(word_addr(20'h0, idx[i]), data, strb, resp);
			check_value("d_b_o.resp", resp, OKAY);
			ref_mem[idx[i]] = merge_strobe(ref_mem[idx[i]], data, strb);
		end
		for (int i = 0; i < num_words; i++) begin
			data_read(word_addr(20'h0, idx[i]), rd, resp);
			check_value("d_r_o.data", rd, ref_mem[idx[i]]);
			check_value("d_r_o.resp", resp, OKAY);
			fetch_read(word_addr(20'h0, idx[i]), rd, resp);
			check_value("if_r_o.data", rd, ref_mem[idx[i]]);
			check_value("if_r_o.resp", resp, OKAY);
		end
	endtask

	task automatic test_uart_tx();
		logic [31:0] data;
		logic [31:0] rd;
		logic [1:0]  resp;
		int          count_before;
		// memory word behind the same offset
		data = $random(seed);
		data_write(word_addr(20'h0, tx_ofs[11:2]), data, 4'hf, resp);
		ref_mem[tx_ofs[11:2]] = data;
		count_before = tx_count;
		data = $random(seed);
		data_write({`UART_REGION, `UART_TX_OFS}, data, 4'hf, resp);
		check_value("d_b_o.resp", resp, OKAY);
		check_value("tx_valid_o pulses", tx_count, count_before + 1);
		check_value("tx_byte_o", tx_last, data[7:0]);
		data_read({`UART_REGION, `UART_TX_OFS}, rd, resp);
		check_value("d_r_o.data", rd, ref_mem[tx_ofs[11:2]]);
		check_value("tx_valid_o pulses", tx_count, count_before + 1);
	endtask

	task automatic test_uart_bad_offset();
		logic [1:0] resp;
		int         count_before;
		count_before = tx_count;
		data_write({`UART_REGION, 12'h004}, $random(seed), 4'hf, resp);
		check_value("d_b_o.resp", resp, SLVERR);
		data_write({`UART_REGION, 12'h3fc}, $random(seed), 4'hf, resp);
		check_value("d_b_o.resp", resp, SLVERR);
		check_value("tx_valid_o pulses", tx_count, count_before);
	endtask

	task automatic test_fetch_priority();
		logic [9:0]  idx;
		logic [31:0] data;
		logic [31:0] old;
		logic [31:0] rd;
		logic [1:0]  resp_f;
		logic [1:0]  resp_w;
		idx  = 10'h155;
		data = $random(seed);
		data_write(word_addr(20'h0, idx), data, 4'hf, resp_w);
		ref_mem[idx] = data;
		old  = data;
		data = $random(seed);
		// both masters raise valid in the same cycle
		fork
			fetch_read(word_addr(20'h0, idx), rd, resp_f);
			data_write(word_addr(20'h0, idx), data, 4'hf, resp_w);
		join
		assert (fetch_done_t < write_done_t)
		else begin
			errors++;
			$display("[ERROR] %0t write response arrived before the fetch response", $time);
		end
		check_value("if_r_o.data", rd, old);
		check_value("if_r_o.resp", resp_f, OKAY);
		check_value("d_b_o.resp", resp_w, OKAY);
		ref_mem[idx] = data;
		data_read(word_addr(20'h0, idx), rd, resp_f);
		check_value("d_r_o.data", rd, ref_mem[idx]);
	endtask

	task automatic test_fetch_backpressure();
		logic [9:0]  idx_f;
		logic [9:0]  idx_d;
		logic [31:0] held;
		logic [1:0]  resp;
		idx_f = 10'h2a7;
		idx_d = 10'h0c3;
		data_write(word_addr(20'h0, idx_f), $random(seed), 4'hf, resp);
		ref_mem[idx_f] = d_w.data;
		data_write(word_addr(20'h0, idx_d), $random(seed), 4'hf, resp);
		ref_mem[idx_d] = d_w.data;
		@(posedge clk);
		#1;
		if_ar.addr.raw = word_addr(20'h0, idx_f);
		if_ar.valid    = 1'b1;
		if_rready      = 1'b0;
		d_ar.addr.raw  = word_addr(20'h0, idx_d);
		d_ar.valid     = 1'b1;
		d_rready       = 1'b1;
		do @(negedge clk); while (if_arready !== 1'b1);
		@(posedge clk);
		#1;
		if_ar.valid = 1'b0;
		do @(negedge clk); while (if_r.valid !== 1'b1);
		held = if_r.data;
		check_value("if_r_o.data", held, ref_mem[idx_f]);
		repeat (hold_cycles) begin
			@(negedge clk);
			check_value("if_r_o.valid", if_r.valid, 1'b1);
			check_value("if_r_o.data", if_r.data, held);
			check_value("d_arready_o", d_arready, 1'b0);
			check_value("d_r_o.valid", d_r.valid, 1'b0);
		end
		@(posedge clk);
		#1;
		if_rready = 1'b1;
		@(posedge clk);
		#1;
		if_rready = 1'b0;
		// the data read now gets the path
		do @(negedge clk); while (d_arready !== 1'b1);
		@(posedge clk);
		#1;
		d_ar.valid = 1'b0;
		do @(negedge clk); while (d_r.valid !== 1'b1);
		check_value("d_r_o.data", d_r.data, ref_mem[idx_d]);
		check_value("d_r_o.resp", d_r.resp, OKAY);
		@(posedge clk);
		#1;
		d_rready = 1'b0;
	endtask

	// ============================================================
	// sequence
	// ============================================================
	initial begin
		test_reset();
		test_strobe_rw();
		test_uart_tx();
		test_uart_bad_offset();
		test_fetch_priority();
		test_fetch_backpressure();
		$display("errors: %0d, checks: %0d, tx pulses: %0d", errors, checks, tx_count);
		if (errors == 0) begin
			$display("SIMULATION PASSED");
		end else begin
			$display("SIMULATION FAILED");
		end
		$finish;
	end

endmodule

//--- list.f
+incdir+include
design/bus_pkg.sv
design/bus_arbiter.sv
design/sram_slave.sv
design/uart_slave.sv
design/mem_subsys_top.sv
verification/tb_mem_subsys.sv

//--- Bender.yml
package:
  name: mem_subsys

sources:
  - include_dirs:
      - include
    files:
      - design/bus_pkg.sv
      - design/bus_arbiter.sv
      - design/sram_slave.sv
      - design/uart_slave.sv
      - design/mem_subsys_top.sv

  - target: test
    include_dirs:
      - include
    files:
      - verification/tb_mem_subsys.sv
